//--- bench/tb_karatsuba_34b.sv
`timescale 1ns/1ps
`default_nettype none

module tb_karatsuba_34b
  import kara_width_pkg::*;
();

  localparam int N_RAND      = 300;
  localparam int N_CORNER    = 8;
  localparam int N_BUSY      = 12;
  localparam int N_TESTS     = N_RAND + N_CORNER + N_BUSY;
  localparam int TEST_BOUND  = 4 * MUL_W + 20;
  localparam int CLK_NS      = 10;
  localparam int WATCHDOG_NS = (N_TESTS * TEST_BOUND + 100) * CLK_NS;
  localparam logic [15:0] LFSR_SEED = 16'd5658;
  localparam logic [OP_W-1:0] ONES  = {OP_W{1'b1}};

  logic             clk_i;
  logic             arst_n_i;
  logic             start_i;
  logic [OP_W-1:0]  a_i;
  logic [OP_W-1:0]  b_i;
  logic             busy_o;
  logic             done_o;
  logic [RES_W-1:0] product_o;

  logic [15:0]      lfsr_q;
  int               mismatch_cnt;
  int               other_cnt;
  int               accepted_cnt;
  int               done_cnt;
  logic             have_result;
  logic             hung;
  logic [RES_W-1:0] last_product;
  logic [OP_W-1:0]  corner_a [N_CORNER];
  logic [OP_W-1:0]  corner_b [N_CORNER];

  karatsuba_34b_top i_dut (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .start_i   (start_i),
    .a_i       (a_i),
    .b_i       (b_i),
    .busy_o    (busy_o),
    .done_o    (done_o),
    .product_o (product_o)
  );

  always #(CLK_NS / 2) clk_i = ~clk_i;

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end else begin
      return s >> 1;
    end
  endfunction

  task automatic take_bits(input int n, output logic [OP_W-1:0] w);
    w = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w = {w[OP_W-2:0], lfsr_q[0]};
    end
  endtask

  // Done pulse count and result hold while idle
  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (done_o) begin
        done_cnt++;
      end
      if (have_result && !busy_o && product_o !== last_product) begin
        $display("mismatch at %0t: product_o (held) expected %h observed %h",
                 $time, last_product, product_o);
        mismatch_cnt++;
      end
    end
  end

  task automatic multiply(input logic [OP_W-1:0] a, input logic [OP_W-1:0] b,
                          input logic poke_busy);
    logic [RES_W-1:0] expected;
    logic [OP_W-1:0]  gap;
    logic [OP_W-1:0]  poke_a;
    logic [OP_W-1:0]  poke_b;
    int               cycles;
    int               done_before;
    expected = RES_W'(a) * RES_W'(b);
    take_bits(2, gap);
    repeat (int'(gap)) @(posedge clk_i);
    @(posedge clk_i);
    done_before = done_cnt;
    start_i <= 1'b1;
    a_i     <= a;
    b_i     <= b;
    @(posedge clk_i);
    start_i <= 1'b0;
    a_i     <= ~a;
    b_i     <= ~b;
    accepted_cnt++;
    if (poke_busy) begin
      // Second start with other operands, well inside the busy window
      take_bits(4, gap);
      take_bits(OP_W, poke_a);
      take_bits(OP_W, poke_b);
      repeat (int'(gap)) @(posedge clk_i);
      start_i <= 1'b1;
      a_i     <= poke_a;
      b_i     <= poke_b;
      @(negedge clk_i);
      if (!busy_o) begin
        $display("error at %0t: busy_o low while a multiplication is in progress", $time);
        other_cnt++;
      end
      @(posedge clk_i);
      start_i <= 1'b0;
    end
    @(negedge clk_i);
    if (!busy_o && !done_o) begin
      $display("error at %0t: busy_o low after an accepted start_i", $time);
      other_cnt++;
    end
    cycles = 0;
    while (!done_o && cycles < TEST_BOUND) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!done_o) begin
      $display("error at %0t: done_o did not arrive within %0d cycles", $time, TEST_BOUND);
      other_cnt++;
      hung = 1'b1;
    end else begin
      if (product_o !== expected) begin
        $display("mismatch at %0t: product_o expected %h observed %h (a %h b %h)",
                 $time, expected, product_o, a, b);
        mismatch_cnt++;
      end
      last_product = expected;
      have_result  = 1'b1;
      @(posedge clk_i);
      if (done_cnt != done_before + 1) begin
        $display("error at %0t: expected one done_o pulse for this start, counted %0d",
                 $time, done_cnt - done_before);
        other_cnt++;
      end
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("error at %0t: watchdog expired before the tests completed", $time);
    other_cnt++;
    $display("tests %0d, done pulses %0d, mismatches %0d, other errors %0d",
             accepted_cnt, done_cnt, mismatch_cnt, other_cnt);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    logic [OP_W-1:0] rand_a;
    logic [OP_W-1:0] rand_b;
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    start_i      = 1'b0;
    a_i          = '0;
    b_i          = '0;
    lfsr_q       = LFSR_SEED;
    mismatch_cnt = 0;
    other_cnt    = 0;
    accepted_cnt = 0;
    done_cnt     = 0;
    have_result  = 1'b0;
    hung         = 1'b0;
    last_product = '0;

    // Zero, one, all ones, half sums that carry into bit 17
    corner_a[0] = '0;
    corner_b[0] = '0;
    corner_a[1] = '0;
    corner_b[1] = ONES;
    corner_a[2] = 34'd1;
    corner_b[2] = 34'd1;
    corner_a[3] = 34'd1;
    corner_b[3] = ONES;
    corner_a[4] = ONES;
    corner_b[4] = ONES;
    corner_a[5] = {17'h1FFFF, 17'h00001};
    corner_b[5] = {17'h00001, 17'h1FFFF};
    corner_a[6] = {17'h10000, 17'h10000};
    corner_b[6] = ONES;
    corner_a[7] = {17'h10000, 17'h00000};
    corner_b[7] = {17'h10000, 17'h00000};

    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;

    repeat (4) begin
      @(negedge clk_i);
      if (busy_o || done_o) begin
        $display("error at %0t: busy_o or done_o high after reset without start_i", $time);
        other_cnt++;
      end
    end

    for (int i = 0; i < N_CORNER && !hung; i++) begin
      multiply(corner_a[i], corner_b[i], 1'b0);
    end
    for (int i = 0; i < N_RAND && !hung; i++) begin
      take_bits(OP_W, rand_a);
      take_bits(OP_W, rand_b);
      multiply(rand_a, rand_b, 1'b0);
    end
    for (int i = 0; i < N_BUSY && !hung; i++) begin
      take_bits(OP_W, rand_a);
      take_bits(OP_W, rand_b);
      multiply(rand_a, rand_b, 1'b1);
    end

    repeat (4) @(negedge clk_i);
    if (done_cnt != accepted_cnt) begin
      $display("error at %0t: %0d accepted starts but %0d done_o pulses",
               $time, accepted_cnt, done_cnt);
      other_cnt++;
    end

    $display("tests %0d, done pulses %0d, mismatches %0d, other errors %0d",
             accepted_cnt, done_cnt, mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/cla_adder.sv
`timescale 1ns/1ps
`default_nettype none

module cla_adder
  import kara_width_pkg::*;
(
  input  logic [RES_W-1:0] a_i,
  input  logic [RES_W-1:0] b_i,
  input  logic             sub_i,
  output logic [RES_W-1:0] sum_o
);

  logic [RES_W-1:0]    b_eff;
  logic [RES_W-1:0]    g;
  logic [RES_W-1:0]    p;
  logic [CLA_GRPS-1:0] gc;

  // Two's complement subtract
  assign b_eff = sub_i ? ~b_i : b_i;
  assign g     = a_i & b_eff;
  assign p     = a_i ^ b_eff;
  assign gc[0] = sub_i;

  for (genvar k = 0; k < CLA_GRPS; k++) begin : g_grp
    logic [CLA_GRP_W-1:0] gg;
    logic [CLA_GRP_W-1:0] pp;
    logic [CLA_GRP_W-1:0] cc;

    assign gg    = g[k*CLA_GRP_W +: CLA_GRP_W];
    assign pp    = p[k*CLA_GRP_W +: CLA_GRP_W];
    assign cc[0] = gc[k];
    assign cc[1] = gg[0] | (pp[0] & cc[0]);
    assign cc[2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & cc[0]);
    assign cc[3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
                 | (pp[2] & pp[1] & pp[0] & cc[0]);

    assign sum_o[k*CLA_GRP_W +: CLA_GRP_W] = pp ^ cc;

    // Group carry ripples into the next group
    if (k < CLA_GRPS - 1) begin : g_cout
      assign gc[k+1] = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1])
                     | (pp[3] & pp[2] & pp[1] & gg[0]) | ((&pp) & cc[0]);
    end
  end

endmodule

`default_nettype wire

//--- rtl/kara_ctrl_pkg.sv
`default_nettype none

package kara_ctrl_pkg;

  typedef enum logic [3:0] {
    IDLE,
    SUM_A,
    SUM_B,
    WAIT_MUL,
    Z1_SUM,
    Z1_SUB,
    ASM_HI,
    ASM_LO,
    FINISH
  } kara_state_t;

  // Adder operand A
  localparam logic [1:0] ALU_A_AH  = 2'd0;
  localparam logic [1:0] ALU_A_BH  = 2'd1;
  localparam logic [1:0] ALU_A_MUL = 2'd2;
  localparam logic [1:0] ALU_A_RES = 2'd3;

  // Adder operand B
  localparam logic [1:0] ALU_B_AL  = 2'd0;
  localparam logic [1:0] ALU_B_BL  = 2'd1;
  localparam logic [1:0] ALU_B_ACC = 2'd2;
  localparam logic [1:0] ALU_B_Z0  = 2'd3;

  // Product feeding the A-side multiplier path
  localparam logic MUL_A1_KARA3 = 1'b0;
  localparam logic MUL_A1_Z2    = 1'b1;

endpackage

`default_nettype wire

//--- rtl/kara_width_pkg.sv
`default_nettype none

package kara_width_pkg;

  // Operand split
  localparam int OP_W   = 34;
  localparam int HALF_W = OP_W / 2;

  // One half plus a carry bit, wide enough for a half sum
  localparam int MUL_W  = HALF_W + 1;
  localparam int PROD_W = 2 * MUL_W;

  // Full product and adder width
  localparam int RES_W  = 2 * OP_W;

  // Placement of z1 and z2 in the result
  localparam int SHIFT_LO = HALF_W;
  localparam int SHIFT_HI = OP_W;

  // Iteration counter of one 18-bit multiplier
  localparam int CNT_W = $clog2(MUL_W + 1);

  // Lookahead groups of the shared adder
  localparam int CLA_GRP_W = 4;
  localparam int CLA_GRPS  = RES_W / CLA_GRP_W;

endpackage

`default_nettype wire

//--- rtl/karatsuba_18b.sv
`timescale 1ns/1ps
`default_nettype none

module karatsuba_18b
  import kara_width_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              start_i,
  input  logic [MUL_W-1:0]  a_i,
  input  logic [MUL_W-1:0]  b_i,
  output logic [PROD_W-1:0] prod_o,
  output logic              done_o
);

  logic [PROD_W-1:0] mcand_q;
  logic [MUL_W-1:0]  mplier_q;
  logic [PROD_W-1:0] acc_q;
  logic              busy;
  logic              last;

  mul_step_counter i_step_cnt (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .start_i  (start_i),
    .busy_o   (busy),
    .last_o   (last)
  );

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mcand_q  <= '0;
      mplier_q <= '0;
      acc_q    <= '0;
      done_o   <= 1'b0;
    end else begin
      done_o <= last & ~start_i;
      if (start_i) begin
        mcand_q  <= {{(PROD_W-MUL_W){1'b0}}, a_i};
        mplier_q <= b_i;
        acc_q    <= '0;
      end else if (busy) begin
        // Shift-add, LSB of the multiplier first
        if (mplier_q[0]) begin
          acc_q <= acc_q + mcand_q;
        end
        mcand_q  <= mcand_q << 1;
        mplier_q <= mplier_q >> 1;
      end
    end
  end

  assign prod_o = acc_q;

endmodule

`default_nettype wire

//--- rtl/karatsuba_34b_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module karatsuba_34b_ctrl
  import kara_ctrl_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       start_i,
  input  logic       done1_i,
  input  logic       done2_i,
  input  logic       done3_i,
  output logic       busy_o,
  output logic       done_o,
  output logic       capture_o,
  output logic       start1_o,
  output logic       start2_o,
  output logic       start3_o,
  output logic       load_reg1_o,
  output logic       load_reg2_o,
  output logic       load_reg3_o,
  output logic [1:0] sel_alu_a_o,
  output logic [1:0] sel_alu_b_o,
  output logic       sel_alu_a1_o,
  output logic       shamt_o,
  output logic       sub_o
);

  kara_state_t state_q;
  kara_state_t state_d;
  logic        seen1_q;
  logic        seen2_q;
  logic        seen3_q;
  logic        all_done;

  assign capture_o = (state_q == IDLE) & start_i;
  assign busy_o    = (state_q != IDLE);
  assign done_o    = (state_q == FINISH);
  assign all_done  = seen1_q & seen2_q & seen3_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Done pulses land in different cycles
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      seen1_q <= 1'b0;
      seen2_q <= 1'b0;
      seen3_q <= 1'b0;
    end else if (capture_o) begin
      seen1_q <= 1'b0;
      seen2_q <= 1'b0;
      seen3_q <= 1'b0;
    end else begin
      seen1_q <= seen1_q | done1_i;
      seen2_q <= seen2_q | done2_i;
      seen3_q <= seen3_q | done3_i;
    end
  end

  always_comb begin
    case (state_q)
      IDLE:     state_d = start_i ? SUM_A : IDLE;
      SUM_A:    state_d = SUM_B;
      SUM_B:    state_d = WAIT_MUL;
      WAIT_MUL: state_d = all_done ? Z1_SUM : WAIT_MUL;
      Z1_SUM:   state_d = Z1_SUB;
      Z1_SUB:   state_d = ASM_HI;
      ASM_HI:   state_d = ASM_LO;
      ASM_LO:   state_d = FINISH;
      default:  state_d = IDLE;
    endcase
  end

  always_comb begin
    start1_o     = 1'b0;
    start2_o     = 1'b0;
    start3_o     = 1'b0;
    load_reg1_o  = 1'b0;
    load_reg2_o  = 1'b0;
    load_reg3_o  = 1'b0;
    sel_alu_a_o  = ALU_A_AH;
    sel_alu_b_o  = ALU_B_AL;
    sel_alu_a1_o = MUL_A1_Z2;
    shamt_o      = 1'b0;
    sub_o        = 1'b0;
    case (state_q)
      // aH+aL into reg2
      SUM_A: begin
        start1_o    = 1'b1;
        start2_o    = 1'b1;
        load_reg2_o = 1'b1;
      end
      SUM_B: begin
        sel_alu_a_o = ALU_A_BH;
        sel_alu_b_o = ALU_B_BL;
        start3_o    = 1'b1;
      end
      Z1_SUM: begin
        sel_alu_a_o = ALU_A_MUL;
        sel_alu_b_o = ALU_B_Z0;
        load_reg3_o = 1'b1;
      end
      // z1 = kara3 - (z2 + z0)
      Z1_SUB: begin
        sel_alu_a_o  = ALU_A_MUL;
        sel_alu_a1_o = MUL_A1_KARA3;
        sel_alu_b_o  = ALU_B_ACC;
        sub_o        = 1'b1;
        load_reg3_o  = 1'b1;
      end
      ASM_HI: begin
        sel_alu_a_o = ALU_A_MUL;
        sel_alu_b_o = ALU_B_ACC;
        shamt_o     = 1'b1;
        load_reg1_o = 1'b1;
        load_reg2_o = 1'b1;
      end
      ASM_LO: begin
        sel_alu_a_o = ALU_A_RES;
        sel_alu_b_o = ALU_B_Z0;
        load_reg1_o = 1'b1;
        load_reg2_o = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/karatsuba_34b_dp.sv
`timescale 1ns/1ps
`default_nettype none

module karatsuba_34b_dp
  import kara_width_pkg::*;
  import kara_ctrl_pkg::*;
(
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic [OP_W-1:0]  a_i,
  input  logic [OP_W-1:0]  b_i,
  input  logic             capture_i,
  input  logic             start1_i,
  input  logic             start2_i,
  input  logic             start3_i,
  input  logic             load_reg1_i,
  input  logic             load_reg2_i,
  input  logic             load_reg3_i,
  input  logic [1:0]       sel_alu_a_i,
  input  logic [1:0]       sel_alu_b_i,
  input  logic             sel_alu_a1_i,
  input  logic             shamt_i,
  input  logic             sub_i,
  output logic             done1_o,
  output logic             done2_o,
  output logic             done3_o,
  output logic [RES_W-1:0] product_o
);

  logic [OP_W-1:0]   a_q;
  logic [OP_W-1:0]   b_q;
  logic [HALF_W-1:0] a_hi;
  logic [HALF_W-1:0] a_lo;
  logic [HALF_W-1:0] b_hi;
  logic [HALF_W-1:0] b_lo;
  logic [PROD_W-1:0] z2;
  logic [PROD_W-1:0] z0;
  logic [PROD_W-1:0] kara3_p;
  logic [OP_W-1:0]   reg1_q;
  logic [OP_W-1:0]   reg2_q;
  logic [PROD_W-1:0] reg3_q;
  logic [PROD_W-1:0] mul_sel;
  logic [RES_W-1:0]  mul_term;
  logic [RES_W-1:0]  acc_term;
  logic [RES_W-1:0]  alu_a;
  logic [RES_W-1:0]  alu_b;
  logic [RES_W-1:0]  adder_sum;

  assign a_hi = a_q[OP_W-1:HALF_W];
  assign a_lo = a_q[HALF_W-1:0];
  assign b_hi = b_q[OP_W-1:HALF_W];
  assign b_lo = b_q[HALF_W-1:0];

  // z2 = aH * bH
  karatsuba_18b kara1 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .start_i  (start1_i),
    .a_i      ({1'b0, a_hi}),
    .b_i      ({1'b0, b_hi}),
    .prod_o   (z2),
    .done_o   (done1_o)
  );

  // z0 = aL * bL
  karatsuba_18b kara2 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .start_i  (start2_i),
    .a_i      ({1'b0, a_lo}),
    .b_i      ({1'b0, b_lo}),
    .prod_o   (z0),
    .done_o   (done2_o)
  );

  // Half sums: aH+aL from reg2, bH+bL straight off the adder
  karatsuba_18b kara3 (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .start_i  (start3_i),
    .a_i      (reg2_q[MUL_W-1:0]),
    .b_i      (adder_sum[MUL_W-1:0]),
    .prod_o   (kara3_p),
    .done_o   (done3_o)
  );

  assign mul_sel  = (sel_alu_a1_i == MUL_A1_Z2) ? z2 : kara3_p;
  assign mul_term = shamt_i ? RES_W'(mul_sel) << SHIFT_HI : RES_W'(mul_sel);
  assign acc_term = shamt_i ? RES_W'(reg3_q) << SHIFT_LO : RES_W'(reg3_q);

  always_comb begin
    case (sel_alu_a_i)
      ALU_A_AH:  alu_a = RES_W'(a_hi);
      ALU_A_BH:  alu_a = RES_W'(b_hi);
      ALU_A_MUL: alu_a = mul_term;
      ALU_A_RES: alu_a = {reg1_q, reg2_q};
      default:   alu_a = '0;
    endcase
  end

  always_comb begin
    case (sel_alu_b_i)
      ALU_B_AL:  alu_b = RES_W'(a_lo);
      ALU_B_BL:  alu_b = RES_W'(b_lo);
      ALU_B_ACC: alu_b = acc_term;
      ALU_B_Z0:  alu_b = RES_W'(z0);
      default:   alu_b = '0;
    endcase
  end

  cla_adder i_add (
    .a_i   (alu_a),
    .b_i   (alu_b),
    .sub_i (sub_i),
    .sum_o (adder_sum)
  );

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_q <= '0;
      b_q <= '0;
    end else if (capture_i) begin
      a_q <= a_i;
      b_q <= b_i;
    end
  end

  // reg1:reg2 hold the result, reg3 holds z2+z0 and then z1
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg1_q <= '0;
      reg2_q <= '0;
      reg3_q <= '0;
    end else begin
      if (load_reg1_i) begin
        reg1_q <= adder_sum[RES_W-1:OP_W];
      end
      if (load_reg2_i) begin
        reg2_q <= adder_sum[OP_W-1:0];
      end
      if (load_reg3_i) begin
        reg3_q <= adder_sum[PROD_W-1:0];
      end
    end
  end

  assign product_o = {reg1_q, reg2_q};

endmodule

`default_nettype wire

//--- rtl/karatsuba_34b_top.sv
`timescale 1ns/1ps
`default_nettype none

module karatsuba_34b_top
  import kara_width_pkg::*;
(
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             start_i,
  input  logic [OP_W-1:0]  a_i,
  input  logic [OP_W-1:0]  b_i,
  output logic             busy_o,
  output logic             done_o,
  output logic [RES_W-1:0] product_o
);

  logic       capture;
  logic       start1;
  logic       start2;
  logic       start3;
  logic       load_reg1;
  logic       load_reg2;
  logic       load_reg3;
  logic [1:0] sel_alu_a;
  logic [1:0] sel_alu_b;
  logic       sel_alu_a1;
  logic       shamt;
  logic       sub;
  logic       done1;
  logic       done2;
  logic       done3;

  karatsuba_34b_ctrl i_ctrl (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .start_i      (start_i),
    .done1_i      (done1),
    .done2_i      (done2),
    .done3_i      (done3),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .capture_o    (capture),
    .start1_o     (start1),
    .start2_o     (start2),
    .start3_o     (start3),
    .load_reg1_o  (load_reg1),
    .load_reg2_o  (load_reg2),
    .load_reg3_o  (load_reg3),
    .sel_alu_a_o  (sel_alu_a),
    .sel_alu_b_o  (sel_alu_b),
    .sel_alu_a1_o (sel_alu_a1),
    .shamt_o      (shamt),
    .sub_o        (sub)
  );

  karatsuba_34b_dp i_dp (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .a_i          (a_i),
    .b_i          (b_i),
    .capture_i    (capture),
    .start1_i     (start1),
    .start2_i     (start2),
    .start3_i     (start3),
    .load_reg1_i  (load_reg1),
    .load_reg2_i  (load_reg2),
    .load_reg3_i  (load_reg3),
    .sel_alu_a_i  (sel_alu_a),
    .sel_alu_b_i  (sel_alu_b),
    .sel_alu_a1_i (sel_alu_a1),
    .shamt_i      (shamt),
    .sub_i        (sub),
    .done1_o      (done1),
    .done2_o      (done2),
    .done3_o      (done3),
    .product_o    (product_o)
  );

endmodule

`default_nettype wire

//--- rtl/mul_step_counter.sv
`timescale 1ns/1ps
`default_nettype none

module mul_step_counter
  import kara_width_pkg::*;
(
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic start_i,
  output logic busy_o,
  output logic last_o
);

  logic [CNT_W-1:0] count_q;

  // One iteration per multiplier bit
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (start_i) begin
      count_q <= CNT_W'(MUL_W);
    end else if (busy_o) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign busy_o = (count_q != '0);
  assign last_o = (count_q == CNT_W'(1));

endmodule

`default_nettype wire

//--- vlog.f
rtl/kara_width_pkg.sv
rtl/kara_ctrl_pkg.sv
rtl/cla_adder.sv
rtl/mul_step_counter.sv
rtl/karatsuba_18b.sv
rtl/karatsuba_34b_dp.sv
rtl/karatsuba_34b_ctrl.sv
rtl/karatsuba_34b_top.sv
bench/tb_karatsuba_34b.sv
